/* logic/uart_periph_pkg.sv */
`default_nettype none

package uart_periph_pkg;

    // Payload width of a serial frame and of one FIFO entry.
    localparam int byte_bits = 8;

    // Request driven by the bus master.
    typedef struct packed {
        logic        read;       // One-cycle read strobe.
        logic        write;      // One-cycle write strobe.
        logic [31:0] address;
        logic [31:0] write_data;
    } bus_req_t;

    // Answer returned by the peripheral.
    typedef struct packed {
        logic        response;   // One-cycle end of access.
        logic [31:0] read_data;  // Valid with response, held until next read.
    } bus_rsp_t;

    // Bus-side controller states.
    typedef enum logic [2:0] {
        idle,
        latch,
        write_bytes,
        read_bytes,
        respond
    } bridge_state_t;

endpackage

`default_nettype wire

/* logic/byte_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module byte_fifo #(
    parameter int depth = 8
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 push,
    input  logic [uart_periph_pkg::byte_bits-1:0] push_data,
    input  logic                                 pop,
    output logic                                 full,
    output logic                                 empty,
    output logic [uart_periph_pkg::byte_bits-1:0] head
);

    localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_bits = $clog2(depth + 1);
    localparam logic [ptr_bits-1:0] last_slot = ptr_bits'(depth - 1);

    logic [uart_periph_pkg::byte_bits-1:0] mem [depth];
    logic [ptr_bits-1:0]   wr_ptr;
    logic [ptr_bits-1:0]   rd_ptr;
    logic [count_bits-1:0] count;
    logic                  do_push;
    logic                  do_pop;

    assign do_push = push && !full;  // Writes to a full buffer are ignored.
    assign do_pop  = pop && !empty;
    assign full    = (count == count_bits'(depth));
    assign empty   = (count == '0);
    assign head    = mem[rd_ptr];    // Oldest entry.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;  // Wrap around.
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither.
            endcase
        end
    end

    // The reader must look at empty before popping.
    pop_not_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("FIFO popped while empty.");

endmodule

`default_nettype wire

/* logic/uart_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
    parameter int clk_freq = 25_000_000,
    parameter int bit_rate = 9600
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 rx,
    output logic                                 valid,
    output logic [uart_periph_pkg::byte_bits-1:0] data
);

    localparam int cpb = clk_freq / bit_rate;  // Clocks per bit.
    localparam int half_bit = cpb / 2;
    localparam int cnt_bits = $clog2(cpb + 1);
    localparam int idx_bits = $clog2(uart_periph_pkg::byte_bits);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t           state;
    logic                rx_meta;
    logic                rx_sync;
    logic [cnt_bits-1:0] baud_cnt;
    logic [idx_bits-1:0] bit_idx;
    logic                bit_end;

    assign bit_end = (baud_cnt == cnt_bits'(cpb - 1));

    // Two-flop synchronizer, idles high like the line.
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= rx_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
            valid    <= 1'b0;
        end else begin
            valid <= 1'b0;
            case (state)
                rx_idle: begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    if (!rx_sync) begin
                        state <= rx_start;  // Falling edge of start bit.
                    end
                end
                rx_start: begin
                    if (baud_cnt == cnt_bits'(half_bit - 1)) begin
                        baud_cnt <= '0;
                        state    <= rx_sync ? rx_idle : rx_data;  // Glitch check at mid start.
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == idx_bits'(uart_periph_pkg::byte_bits - 1)) begin
                            state <= rx_stop;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (bit_end) begin
                        valid <= rx_sync;  // Framing error drops the byte.
                        state <= rx_idle;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // Mid-bit sample, least significant bit arrives first.
    always_ff @(posedge clk) begin
        if (state == rx_data && bit_end) begin
            data <= {rx_sync, data[uart_periph_pkg::byte_bits-1:1]};
        end
    end

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
    parameter int clk_freq = 25_000_000,
    parameter int bit_rate = 9600
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 start,
    input  logic [uart_periph_pkg::byte_bits-1:0] data,
    output logic                                 tx,
    output logic                                 busy
);

    localparam int cpb = clk_freq / bit_rate;  // Clocks per bit.
    localparam int cnt_bits = $clog2(cpb + 1);
    localparam int frame_bits = uart_periph_pkg::byte_bits + 2;  // Start, data, stop.
    localparam int idx_bits = $clog2(frame_bits);

    logic [frame_bits-1:0] frame;
    logic [cnt_bits-1:0]   baud_cnt;
    logic [idx_bits-1:0]   bit_cnt;

    assign tx = frame[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            frame    <= '1;  // Line idles high.
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            if (start) begin
                frame    <= {1'b1, data, 1'b0};
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (baud_cnt == cnt_bits'(cpb - 1)) begin
            baud_cnt <= '0;
            if (bit_cnt == idx_bits'(frame_bits - 1)) begin
                busy <= 1'b0;  // Stop bit done.
            end else begin
                frame   <= {1'b1, frame[frame_bits-1:1]};
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // The bridge must wait for busy to fall before the next byte.
    start_when_free: assert property (@(posedge clk) disable iff (reset) start |-> !busy)
        else $error("Transmit start while busy.");

endmodule

`default_nettype wire

/* logic/uart_bus_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_bus_bridge #(
    parameter int          word_bytes     = 4,
    parameter logic [31:0] dev_start_addr = 32'h0000_2007,
    parameter logic [31:0] dev_final_addr = 32'h0000_23BA
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  uart_periph_pkg::bus_req_t            bus_req,
    output uart_periph_pkg::bus_rsp_t            bus_rsp,
    output logic                                 tx_push,
    output logic [uart_periph_pkg::byte_bits-1:0] tx_push_data,
    output logic                                 tx_pop,
    input  logic                                 tx_full,
    input  logic                                 tx_empty,
    input  logic [uart_periph_pkg::byte_bits-1:0] tx_head,
    output logic                                 rx_push,
    output logic [uart_periph_pkg::byte_bits-1:0] rx_push_data,
    output logic                                 rx_pop,
    input  logic                                 rx_full,
    input  logic                                 rx_empty,
    input  logic [uart_periph_pkg::byte_bits-1:0] rx_head,
    output logic                                 tx_start,
    output logic [uart_periph_pkg::byte_bits-1:0] tx_data,
    input  logic                                 tx_busy,
    input  logic                                 rx_valid,
    input  logic [uart_periph_pkg::byte_bits-1:0] rx_data
);

    localparam int bb = uart_periph_pkg::byte_bits;
    localparam logic [2:0] last_byte = 3'(word_bytes - 1);

    uart_periph_pkg::bridge_state_t state;
    uart_periph_pkg::bus_req_t      req_q;
    logic [31:0] word_q;       // Write shift-out or read assembly.
    logic [31:0] read_data_q;
    logic [2:0]  byte_count;
    logic        in_range;

    assign in_range = (req_q.address >= dev_start_addr) && (req_q.address <= dev_final_addr);

    assign bus_rsp.response  = (state == uart_periph_pkg::respond);
    assign bus_rsp.read_data = read_data_q;

    assign tx_push      = (state == uart_periph_pkg::write_bytes) && !tx_full;
    assign tx_push_data = word_q[bb-1:0];  // Least significant byte first.
    assign rx_pop       = (state == uart_periph_pkg::read_bytes) && !rx_empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= uart_periph_pkg::idle;
            byte_count  <= '0;
            read_data_q <= '0;
        end else begin
            case (state)
                uart_periph_pkg::idle: begin
                    byte_count <= '0;
                    if (bus_req.read || bus_req.write) begin
                        state <= uart_periph_pkg::latch;
                    end
                end
                uart_periph_pkg::latch: begin
                    if (!in_range) begin
                        if (req_q.read) begin
                            read_data_q <= '0;  // Outside the window reads as zero.
                        end
                        state <= uart_periph_pkg::respond;
                    end else if (req_q.write) begin
                        state <= uart_periph_pkg::write_bytes;
                    end else begin
                        state <= uart_periph_pkg::read_bytes;
                    end
                end
                uart_periph_pkg::write_bytes: begin
                    if (!tx_full) begin  // Stall on a full FIFO.
                        byte_count <= byte_count + 1'b1;
                        if (byte_count == last_byte) begin
                            state <= uart_periph_pkg::respond;
                        end
                    end
                end
                uart_periph_pkg::read_bytes: begin
                    if (!rx_empty) begin  // Stall until a byte arrives.
                        byte_count <= byte_count + 1'b1;
                        if (byte_count == last_byte) begin
                            read_data_q <= {word_q[31-bb:0], rx_head};
                            state       <= uart_periph_pkg::respond;
                        end
                    end
                end
                uart_periph_pkg::respond: state <= uart_periph_pkg::idle;
                default:                  state <= uart_periph_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == uart_periph_pkg::idle && (bus_req.read || bus_req.write)) begin
            req_q <= bus_req;  // Master holds nothing after the strobe.
        end
        if (state == uart_periph_pkg::latch) begin
            word_q <= req_q.write ? req_q.write_data : '0;
        end else if (tx_push) begin
            word_q <= word_q >> bb;
        end else if (rx_pop) begin
            word_q <= {word_q[31-bb:0], rx_head};  // First byte ends up on top.
        end
    end

    // Drain and fill run alongside the bus FSM.
    always_comb begin
        tx_start     = !tx_busy && !tx_empty;
        tx_pop       = tx_start;  // Pop together with the start.
        tx_data      = tx_head;
        rx_push      = rx_valid && !rx_full;  // Overflow bytes are dropped.
        rx_push_data = rx_data;
    end

    response_one_cycle: assert property (@(posedge clk) disable iff (reset)
        bus_rsp.response |=> !bus_rsp.response)
        else $error("Response held longer than one cycle.");

    // A new strobe may only come once the previous access has ended.
    strobe_when_idle: assert property (@(posedge clk) disable iff (reset)
        (bus_req.read || bus_req.write) |-> (state == uart_periph_pkg::idle))
        else $error("Bus strobe arrived while an access was in progress.");

endmodule

`default_nettype wire

/* logic/uart_periph.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_periph #(
    parameter int          clk_freq       = 25_000_000,
    parameter int          bit_rate       = 9600,
    parameter int          buffer_depth   = 8,
    parameter int          word_bytes     = 4,
    parameter logic [31:0] dev_start_addr = 32'h0000_2007,
    parameter logic [31:0] dev_final_addr = 32'h0000_23BA
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      rx,
    output logic                      tx,
    input  uart_periph_pkg::bus_req_t bus_req,
    output uart_periph_pkg::bus_rsp_t bus_rsp
);

    logic                                 tx_push;
    logic                                 tx_pop;
    logic                                 tx_full;
    logic                                 tx_empty;
    logic [uart_periph_pkg::byte_bits-1:0] tx_push_data;
    logic [uart_periph_pkg::byte_bits-1:0] tx_head;
    logic                                 rx_push;
    logic                                 rx_pop;
    logic                                 rx_full;
    logic                                 rx_empty;
    logic [uart_periph_pkg::byte_bits-1:0] rx_push_data;
    logic [uart_periph_pkg::byte_bits-1:0] rx_head;
    logic                                 tx_start;
    logic                                 tx_busy;
    logic [uart_periph_pkg::byte_bits-1:0] tx_data;
    logic                                 rx_valid;
    logic [uart_periph_pkg::byte_bits-1:0] rx_data;

    uart_bus_bridge #(
        .word_bytes    (word_bytes),
        .dev_start_addr(dev_start_addr),
        .dev_final_addr(dev_final_addr)
    ) bridge_i (
        .clk         (clk),
        .reset       (reset),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .tx_push     (tx_push),
        .tx_push_data(tx_push_data),
        .tx_pop      (tx_pop),
        .tx_full     (tx_full),
        .tx_empty    (tx_empty),
        .tx_head     (tx_head),
        .rx_push     (rx_push),
        .rx_push_data(rx_push_data),
        .rx_pop      (rx_pop),
        .rx_full     (rx_full),
        .rx_empty    (rx_empty),
        .rx_head     (rx_head),
        .tx_start    (tx_start),
        .tx_data     (tx_data),
        .tx_busy     (tx_busy),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data)
    );

    byte_fifo #(.depth(buffer_depth)) tx_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (tx_push),
        .push_data(tx_push_data),
        .pop      (tx_pop),
        .full     (tx_full),
        .empty    (tx_empty),
        .head     (tx_head)
    );

    byte_fifo #(.depth(buffer_depth)) rx_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (rx_push),
        .push_data(rx_push_data),
        .pop      (rx_pop),
        .full     (rx_full),
        .empty    (rx_empty),
        .head     (rx_head)
    );

    uart_rx #(.clk_freq(clk_freq), .bit_rate(bit_rate)) uart_rx_i (
        .clk  (clk),
        .reset(reset),
        .rx   (rx),
        .valid(rx_valid),
        .data (rx_data)
    );

    uart_tx #(.clk_freq(clk_freq), .bit_rate(bit_rate)) uart_tx_i (
        .clk  (clk),
        .reset(reset),
        .start(tx_start),
        .data (tx_data),
        .tx   (tx),
        .busy (tx_busy)
    );

endmodule

`default_nettype wire

/* test/uart_periph_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_periph_tb;

    localparam int clk_freq     = 1_000_000;
    localparam int bit_rate     = clk_freq / 10;
    localparam int bit_clocks   = clk_freq / bit_rate;  // Ten clocks per bit.
    localparam int buffer_depth = 4;
    localparam int word_bytes   = 4;

    typedef enum logic [1:0] {
        op_write,
        op_send,
        op_read
    } op_kind_t;

    typedef struct packed {
        op_kind_t    kind;
        logic [31:0] address;
        logic [31:0] data;      // Write word, rx byte, or least rx frame count for a read.
        logic [31:0] expected;  // Tx byte count, wait flag, or read word.
    } test_op_t;

    logic                      clk;
    logic                      reset;
    logic                      rx;
    logic                      tx;
    uart_periph_pkg::bus_req_t bus_req;
    uart_periph_pkg::bus_rsp_t bus_rsp;

    test_op_t   ops[$];
    logic [7:0] send_q[$];       // Bytes waiting for the rx driver.
    logic [7:0] tx_expect_q[$];  // Bytes the monitor must see next on tx.
    logic       driver_busy;
    int         frames_driven;   // Frames whose stop bit has started on rx.
    int         frames_seen;
    int         bytes_written;
    int         value_errors;
    int         other_errors;
    int         cycle_count;
    int         cycle_limit;

    uart_periph #(
        .clk_freq      (clk_freq),
        .bit_rate      (bit_rate),
        .buffer_depth  (buffer_depth),
        .word_bytes    (word_bytes),
        .dev_start_addr(32'h0000_2000),
        .dev_final_addr(32'h0000_20FF)
    ) uart_periph_i (
        .clk    (clk),
        .reset  (reset),
        .rx     (rx),
        .tx     (tx),
        .bus_req(bus_req),
        .bus_rsp(bus_rsp)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic load_ops();
        int          fd;
        int          fields;
        string       line;
        string       kind;
        logic [31:0] address;
        logic [31:0] data;
        logic [31:0] expected;
        test_op_t    op;
        fd = $fopen("test/uart_periph_testdata.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the test data file.");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") begin
                continue;  // Blank or comment line.
            end
            fields = $sscanf(line, "%s %h %h %h", kind, address, data, expected);
            if (fields <= 0) begin
                continue;
            end
            if (fields != 4) begin
                other_errors++;
                $display("Malformed test data line: %s", line);
                continue;
            end
            op.address  = address;
            op.data     = data;
            op.expected = expected;
            if (kind == "write") begin
                op.kind = op_write;
            end else if (kind == "send") begin
                op.kind = op_send;
            end else if (kind == "read") begin
                op.kind = op_read;
            end else begin
                other_errors++;
                $display("Unknown operation in test data: %s", kind);
                continue;
            end
            ops.push_back(op);
        end
        $fclose(fd);
        assert (ops.size() > 0) else begin
            other_errors++;
            $display("The test data file holds no operations.");
        end
    endtask

    // Twice the serial and bus time, plus reset and the closing quiet period.
    function automatic int run_limit();
        int serial_bytes;
        int accesses;
        serial_bytes = 0;
        accesses     = 0;
        foreach (ops[i]) begin
            if (ops[i].kind == op_send) begin
                serial_bytes++;
            end else begin
                accesses++;
                if (ops[i].kind == op_write) begin
                    serial_bytes += int'(ops[i].expected);
                end
            end
        end
        return 2 * (12 * bit_clocks * serial_bytes + 20 * accesses) + 24 * bit_clocks + 10;
    endfunction

    task automatic bus_access(input logic is_write, input logic [31:0] address,
                              input logic [31:0] write_data, output logic [31:0] read_data);
        @(negedge clk);
        bus_req.read       = !is_write;
        bus_req.write      = is_write;
        bus_req.address    = address;
        bus_req.write_data = write_data;
        @(negedge clk);
        bus_req = '0;  // Strobe lasts one cycle.
        while (bus_rsp.response !== 1'b1) begin
            @(negedge clk);
        end
        read_data = bus_rsp.read_data;
        @(negedge clk);
        assert (bus_rsp.response === 1'b0) else begin
            other_errors++;
            $display("Response at %0t lasted longer than one cycle.", $time);
        end
    endtask

    task automatic run_write(input test_op_t op);
        logic [31:0] rdata;
        for (int i = 0; i < int'(op.expected); i++) begin
            tx_expect_q.push_back(op.data[8*i +: 8]);  // Low byte leaves first.
        end
        bus_access(1'b1, op.address, op.data, rdata);
        bytes_written += int'(op.expected);
        // Every byte of the word sits in the FIFO, in the transmitter or on the line.
        assert (bytes_written - frames_seen <= buffer_depth + 1) else begin
            other_errors++;
            $display("Write to %h answered before its bytes had room in the TX FIFO.",
                     op.address);
        end
    endtask

    task automatic run_send(input test_op_t op);
        send_q.push_back(op.data[7:0]);
        if (op.expected != 0) begin
            while (send_q.size() > 0 || driver_busy) begin
                @(negedge clk);
            end
        end
    endtask

    task automatic run_read(input test_op_t op);
        logic [31:0] rdata;
        bus_access(1'b0, op.address, 32'h0, rdata);
        assert (rdata === op.expected) else begin
            value_errors++;
            $display("FAIL at %0t: bus_rsp.read_data expected %h, got %h",
                     $time, op.expected, rdata);
        end
        assert (frames_driven >= int'(op.data)) else begin
            other_errors++;
            $display("Read at %h answered after %0d rx frames, before frame %0d arrived.",
                     op.address, frames_driven, op.data);
        end
    endtask

    initial begin : rx_driver
        logic [9:0] frame;
        @(negedge reset);
        forever begin
            @(negedge clk);
            if (send_q.size() > 0) begin
                driver_busy = 1'b1;
                frame = {1'b1, send_q.pop_front(), 1'b0};  // Stop, data, start.
                for (int b = 0; b < 10; b++) begin
                    if (b == 9) begin
                        frames_driven++;
                    end
                    rx = frame[b];
                    repeat (bit_clocks) @(negedge clk);
                end
                repeat (2 * bit_clocks) @(negedge clk);  // Idle gap between frames.
                driver_busy = 1'b0;
            end
        end
    end

    initial begin : tx_monitor
        logic [7:0] got;
        logic [7:0] want;
        @(negedge reset);
        forever begin
            @(negedge clk);
            if (tx === 1'b0) begin
                repeat (bit_clocks / 2) @(negedge clk);  // Middle of the start bit.
                assert (tx === 1'b0) else begin
                    other_errors++;
                    $display("Start bit on tx ended before mid-bit at %0t.", $time);
                end
                for (int b = 0; b < 8; b++) begin
                    repeat (bit_clocks) @(negedge clk);
                    got[b] = tx;
                end
                repeat (bit_clocks) @(negedge clk);
                assert (tx === 1'b1) else begin
                    other_errors++;
                    $display("Stop bit on tx was low at %0t.", $time);
                end
                frames_seen++;
                assert (tx_expect_q.size() > 0) else begin
                    other_errors++;
                    $display("Unexpected byte %h appeared on tx at %0t.", got, $time);
                end
                if (tx_expect_q.size() > 0) begin
                    want = tx_expect_q.pop_front();
                    assert (got === want) else begin
                        value_errors++;
                        $display("FAIL at %0t: tx expected %h, got %h", $time, want, got);
                    end
                end
            end
        end
    end

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        rx            = 1'b1;
        bus_req       = '0;
        driver_busy   = 1'b0;
        frames_driven = 0;
        frames_seen   = 0;
        bytes_written = 0;
        value_errors  = 0;
        other_errors  = 0;
        cycle_count   = 0;
        cycle_limit   = 1000;
        load_ops();
        cycle_limit = run_limit();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (ops[i]) begin
            case (ops[i].kind)
                op_write: run_write(ops[i]);
                op_send:  run_send(ops[i]);
                default:  run_read(ops[i]);
            endcase
        end
        while (tx_expect_q.size() > 0 || send_q.size() > 0 || driver_busy) begin
            @(negedge clk);
        end
        repeat (24 * bit_clocks) @(negedge clk);  // Quiet time to catch stray tx frames.
        $display("Errors: %0d wrong values, %0d other failures.", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/uart_periph_testdata.txt */
# kind  address  data  expected
# write: data is the word, expected is the byte count that must appear on tx
# send: data is the rx byte, expected 1 waits until the rx line is idle
# read: data is the least rx frame count before the response, expected is the word
write 00002000 44332211 00000004
send  00000000 000000a1 00000000
send  00000000 000000b2 00000000
send  00000000 000000c3 00000000
send  00000000 000000d4 00000001
read  00002004 00000004 a1b2c3d4
send  00000000 00000015 00000000
send  00000000 00000026 00000000
send  00000000 00000037 00000000
send  00000000 00000048 00000000
read  00002008 00000008 15263748
write 00002010 87654321 00000004
write 00002014 0fedcba9 00000004
send  00000000 0000005a 00000000
send  00000000 0000006b 00000000
send  00000000 0000007c 00000000
send  00000000 0000008d 00000001
read  00003000 00000000 00000000
write 00001000 deadbeef 00000000
read  0000200c 0000000c 5a6b7c8d
send  00000000 00000061 00000000
send  00000000 00000062 00000000
send  00000000 00000063 00000000
send  00000000 00000064 00000000
send  00000000 00000065 00000000
send  00000000 00000066 00000001
read  00002000 00000012 61626364
send  00000000 00000071 00000000
send  00000000 00000072 00000000
send  00000000 00000073 00000000
send  00000000 00000074 00000000
read  000020ff 00000016 71727374
write 000020fe 0a0b0c0d 00000004

/* uart_periph.f */
logic/uart_periph_pkg.sv
logic/byte_fifo.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_bus_bridge.sv
logic/uart_periph.sv
test/uart_periph_tb.sv

/* Bender.yml */
package:
  name: uart_periph

sources:
  - files:
      - logic/uart_periph_pkg.sv
      - logic/byte_fifo.sv
      - logic/uart_rx.sv
      - logic/uart_tx.sv
      - logic/uart_bus_bridge.sv
      - logic/uart_periph.sv
  - target: test
    files:
      - test/uart_periph_tb.sv
